//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

    // ------------------------------------------------------------------
    // widths fixed by the RV64I base ISA
    // ------------------------------------------------------------------
    localparam int xlen = 64;
    localparam int ilen = 32;

    // data word, byte address, instruction word, register index
    typedef logic [xlen-1:0] xlen_t;
    typedef logic [xlen-1:0] addr_t;
    typedef logic [ilen-1:0] instr_t;
    typedef logic [4:0]      reg_idx_t;

    // first fetch address after reset
    localparam addr_t reset_pc = '0;

    // ------------------------------------------------------------------
    // major opcodes, one per supported class
    // ------------------------------------------------------------------
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    // funct3 for alu ops
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    // ld and sd share the doubleword size code
    localparam logic [2:0] f3_dword   = 3'b011;
    // conditional branches
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    // funct7 splits add from sub
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

endpackage

//--- src/rv_pipe_pkg.sv
package rv_pipe_pkg;

    // ------------------------------------------------------------------
    // control encodings carried between stages
    // ------------------------------------------------------------------

    // alu function picked in decode
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_e;

    // source of the writeback value, none means no register write
    typedef enum logic [1:0] {
        wb_none,
        wb_alu,
        wb_mem,
        wb_link
    } wb_sel_e;

    // control transfer resolved in execute
    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne,
        br_jal
    } br_kind_e;

    // wishbone master FSM, shared by fetch and memory
    typedef enum logic [1:0] {
        bus_idle,
        bus_wait
    } bus_state_e;

    // addi x0, x0, 0 fills a flushed fetch slot
    localparam rv_isa_pkg::instr_t nop_instr = 32'h0000_0013;

endpackage

//--- src/pipe_links.sv
`timescale 1ns/1ps

// decode to execute register, stall runs backward
interface dec_ex_link;
    logic                  valid;
    rv_isa_pkg::addr_t     pc;
    rv_isa_pkg::xlen_t     rs1_val;
    rv_isa_pkg::xlen_t     rs2_val;
    rv_isa_pkg::xlen_t     imm;
    rv_isa_pkg::reg_idx_t  rd;
    rv_pipe_pkg::alu_op_e  alu_op;
    // operand b is the immediate instead of rs2
    logic                  b_sel_imm;
    rv_pipe_pkg::br_kind_e br_kind;
    rv_pipe_pkg::wb_sel_e  wb_sel;
    logic                  store;
    logic                  stall;

    modport master (
        output valid, pc, rs1_val, rs2_val, imm, rd, alu_op, b_sel_imm,
        output br_kind, wb_sel, store,
        input  stall
    );
    modport slave (
        input  valid, pc, rs1_val, rs2_val, imm, rd, alu_op, b_sel_imm,
        input  br_kind, wb_sel, store,
        output stall
    );
endinterface

// execute to memory/writeback register, busy runs backward
interface ex_mem_link;
    logic                 valid;
    // alu value, load/store address or link pc+4
    rv_isa_pkg::xlen_t    result;
    rv_isa_pkg::xlen_t    store_data;
    rv_isa_pkg::reg_idx_t rd;
    rv_pipe_pkg::wb_sel_e wb_sel;
    logic                 store;
    logic                 busy;

    modport master (output valid, result, store_data, rd, wb_sel, store, input busy);
    modport slave (input valid, result, store_data, rd, wb_sel, store, output busy);
endinterface

//--- src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic               clk,
    input  logic               rst_n,
    output logic               imem_cyc,
    output logic               imem_stb,
    output rv_isa_pkg::addr_t  imem_adr,
    input  rv_isa_pkg::instr_t imem_rdata,
    input  logic               imem_ack,
    input  logic               hold,
    input  logic               redirect,
    input  rv_isa_pkg::addr_t  redirect_pc,
    output logic               valid,
    output rv_isa_pkg::addr_t  pc,
    output rv_isa_pkg::instr_t instr
);

    rv_pipe_pkg::bus_state_e state;
    // address of the next instruction to request
    rv_isa_pkg::addr_t fetch_pc;
    // set when a redirect lands on an open cycle, its word is discarded
    logic drop;
    // decode slot is empty or gets emptied this cycle
    logic slot_free;

    // only one read in flight, and it always finds the slot free on ack
    assign slot_free = !valid || !hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= rv_pipe_pkg::bus_idle;
            imem_cyc <= 1'b0;
            imem_stb <= 1'b0;
            imem_adr <= rv_isa_pkg::reset_pc;
            fetch_pc <= rv_isa_pkg::reset_pc;
            drop     <= 1'b0;
            valid    <= 1'b0;
        end else begin
            // decode took the word
            if (valid && !hold) begin
                valid <= 1'b0;
            end
            // flush the slot and restart at the target
            if (redirect) begin
                valid    <= 1'b0;
                instr    <= rv_pipe_pkg::nop_instr;
                fetch_pc <= redirect_pc;
            end
            case (state)
                rv_pipe_pkg::bus_idle: begin
                    if (!redirect && slot_free) begin
                        imem_cyc <= 1'b1;
                        imem_stb <= 1'b1;
                        imem_adr <= fetch_pc;
                        state    <= rv_pipe_pkg::bus_wait;
                    end
                end
                rv_pipe_pkg::bus_wait: begin
                    if (imem_ack) begin
                        imem_cyc <= 1'b0;
                        imem_stb <= 1'b0;
                        drop     <= 1'b0;
                        state    <= rv_pipe_pkg::bus_idle;
                        // stale word from before a redirect never reaches decode
                        if (!redirect && !drop) begin
                            valid    <= 1'b1;
                            pc       <= imem_adr;
                            instr    <= imem_rdata;
                            fetch_pc <= imem_adr + 64'd4;
                        end
                    end else if (redirect) begin
                        drop <= 1'b1;
                    end
                end
                default: state <= rv_pipe_pkg::bus_idle;
            endcase
        end
    end

    // classic wishbone, the request stays up until the slave answers
    a_stb_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        imem_stb && !imem_ack |=> imem_stb);

endmodule

//--- src/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid,
    input  rv_isa_pkg::addr_t    pc,
    input  rv_isa_pkg::instr_t   instr,
    output logic                 hold,
    input  logic                 redirect,
    input  logic                 wb_we,
    input  rv_isa_pkg::reg_idx_t wb_addr,
    output rv_isa_pkg::reg_idx_t rf_raddr1,
    output rv_isa_pkg::reg_idx_t rf_raddr2,
    input  rv_isa_pkg::xlen_t    rf_rdata1,
    input  rv_isa_pkg::xlen_t    rf_rdata2,
    dec_ex_link.master           ex
);

    // ------------------------------------------------------------------
    // field split and immediates
    // ------------------------------------------------------------------
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::xlen_t imm_i, imm_s, imm_b, imm_j;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7    = instr[31:25];
    assign rd        = instr[11:7];
    assign rf_raddr1 = instr[19:15];
    assign rf_raddr2 = instr[24:20];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // decoded control
    rv_pipe_pkg::alu_op_e  alu_op;
    rv_pipe_pkg::wb_sel_e  wb_sel;
    rv_pipe_pkg::br_kind_e br_kind;
    rv_isa_pkg::xlen_t     imm;
    logic b_sel_imm, store, use_rs1, use_rs2, writes_rd;

    // unsupported encodings fall through as no-ops
    always_comb begin
        alu_op    = rv_pipe_pkg::alu_add;
        wb_sel    = rv_pipe_pkg::wb_none;
        br_kind   = rv_pipe_pkg::br_none;
        imm       = imm_i;
        b_sel_imm = 1'b0;
        store     = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        case (opcode)
            rv_isa_pkg::op_reg: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                wb_sel  = rv_pipe_pkg::wb_alu;
                case (funct3)
                    rv_isa_pkg::f3_add_sub: alu_op = (funct7 == rv_isa_pkg::f7_sub) ?
                                                     rv_pipe_pkg::alu_sub : rv_pipe_pkg::alu_add;
                    rv_isa_pkg::f3_xor:     alu_op = rv_pipe_pkg::alu_xor;
                    rv_isa_pkg::f3_or:      alu_op = rv_pipe_pkg::alu_or;
                    rv_isa_pkg::f3_and:     alu_op = rv_pipe_pkg::alu_and;
                    default:                wb_sel = rv_pipe_pkg::wb_none;
                endcase
                // sub encoding only exists with add funct3
                if (!(funct7 == rv_isa_pkg::f7_base ||
                      (funct7 == rv_isa_pkg::f7_sub && funct3 == rv_isa_pkg::f3_add_sub))) begin
                    wb_sel = rv_pipe_pkg::wb_none;
                end
            end
            rv_isa_pkg::op_imm: begin
                use_rs1   = 1'b1;
                b_sel_imm = 1'b1;
                if (funct3 == rv_isa_pkg::f3_add_sub) wb_sel = rv_pipe_pkg::wb_alu;
            end
            rv_isa_pkg::op_load: begin
                use_rs1   = 1'b1;
                b_sel_imm = 1'b1;
                if (funct3 == rv_isa_pkg::f3_dword) wb_sel = rv_pipe_pkg::wb_mem;
            end
            rv_isa_pkg::op_store: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                b_sel_imm = 1'b1;
                imm       = imm_s;
                store     = (funct3 == rv_isa_pkg::f3_dword);
            end
            rv_isa_pkg::op_branch: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm     = imm_b;
                if (funct3 == rv_isa_pkg::f3_beq) br_kind = rv_pipe_pkg::br_beq;
                if (funct3 == rv_isa_pkg::f3_bne) br_kind = rv_pipe_pkg::br_bne;
            end
            rv_isa_pkg::op_jal: begin
                imm     = imm_j;
                br_kind = rv_pipe_pkg::br_jal;
                wb_sel  = rv_pipe_pkg::wb_link;
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------------
    // scoreboard interlock
    // ------------------------------------------------------------------
    // one bit per register with a write still in flight, x0 never set
    logic [31:0] sb, sb_live, sb_next;
    logic conflict, issue;

    assign writes_rd = (wb_sel != rv_pipe_pkg::wb_none) && (rd != '0);
    // writeback this cycle is visible through the register file bypass
    assign sb_live   = wb_we ? (sb & ~(32'b1 << wb_addr)) : sb;
    // rd is checked too so every bit has a single owner
    assign conflict  = (use_rs1 && sb_live[rf_raddr1]) || (use_rs2 && sb_live[rf_raddr2]) ||
                       (writes_rd && sb_live[rd]);
    assign hold      = valid && (conflict || ex.stall);
    assign issue     = valid && !hold && !redirect;

    always_comb begin
        sb_next = sb_live;
        // a flushed writer gives its bit back
        if (redirect && ex.valid && ex.wb_sel != rv_pipe_pkg::wb_none) sb_next[ex.rd] = 1'b0;
        if (issue && writes_rd) sb_next[rd] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sb       <= '0;
            ex.valid <= 1'b0;
        end else begin
            sb <= sb_next;
            if (redirect) begin
                ex.valid <= 1'b0;
            end else if (!ex.stall) begin
                ex.valid <= issue;
            end
        end
    end

    // operand and control payload
    always_ff @(posedge clk) begin
        if (issue) begin
            ex.pc        <= pc;
            ex.rs1_val   <= rf_rdata1;
            ex.rs2_val   <= rf_rdata2;
            ex.imm       <= imm;
            ex.rd        <= rd;
            ex.alu_op    <= alu_op;
            ex.b_sel_imm <= b_sel_imm;
            ex.br_kind   <= br_kind;
            ex.wb_sel    <= wb_sel;
            ex.store     <= store;
        end
    end

    // a writer still in the execute register must block its readers
    a_no_marked_src: assert property (@(posedge clk) disable iff (!rst_n)
        issue && ex.valid && ex.wb_sel != rv_pipe_pkg::wb_none && ex.rd != '0 |->
            !(use_rs1 && rf_raddr1 == ex.rd) && !(use_rs2 && rf_raddr2 == ex.rd));

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                 clk,
    input  rv_isa_pkg::reg_idx_t raddr1,
    input  rv_isa_pkg::reg_idx_t raddr2,
    output rv_isa_pkg::xlen_t    rdata1,
    output rv_isa_pkg::xlen_t    rdata2,
    input  logic                 we,
    input  rv_isa_pkg::reg_idx_t waddr,
    input  rv_isa_pkg::xlen_t    wdata
);

    rv_isa_pkg::xlen_t regs [32];

    // x0 reads zero, a same-cycle write is passed straight through
    assign rdata1 = (raddr1 == '0) ? '0 :
                    (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 :
                    (we && waddr == raddr2) ? wdata : regs[raddr2];

    // writes to x0 are dropped
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

//--- src/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic              clk,
    input  logic              rst_n,
    dec_ex_link.slave         dec,
    ex_mem_link.master        mem,
    output logic              redirect,
    output rv_isa_pkg::addr_t redirect_pc
);

    rv_isa_pkg::xlen_t op_b, alu_res;
    logic taken, take;

    // the execute register only moves when memory is free
    assign dec.stall = mem.busy;
    // the slot behind a taken branch is dropped
    assign take = dec.valid && !redirect && !mem.busy;
    assign op_b = dec.b_sel_imm ? dec.imm : dec.rs2_val;

    // ------------------------------------------------------------------
    // alu and branch compare
    // ------------------------------------------------------------------
    always_comb begin
        case (dec.alu_op)
            rv_pipe_pkg::alu_sub: alu_res = dec.rs1_val - op_b;
            rv_pipe_pkg::alu_and: alu_res = dec.rs1_val & op_b;
            rv_pipe_pkg::alu_or:  alu_res = dec.rs1_val | op_b;
            rv_pipe_pkg::alu_xor: alu_res = dec.rs1_val ^ op_b;
            default:              alu_res = dec.rs1_val + op_b;
        endcase
    end

    always_comb begin
        case (dec.br_kind)
            rv_pipe_pkg::br_beq: taken = (dec.rs1_val == dec.rs2_val);
            rv_pipe_pkg::br_bne: taken = (dec.rs1_val != dec.rs2_val);
            rv_pipe_pkg::br_jal: taken = 1'b1;
            default:             taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem.valid <= 1'b0;
            redirect  <= 1'b0;
        end else begin
            // one-cycle pulse as the branch enters the register
            redirect <= take && taken;
            if (!mem.busy) begin
                mem.valid <= take;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            // jal links pc+4, loads and stores carry the address
            mem.result     <= (dec.wb_sel == rv_pipe_pkg::wb_link) ? dec.pc + 64'd4 : alu_res;
            mem.store_data <= dec.rs2_val;
            mem.rd         <= dec.rd;
            mem.wb_sel     <= dec.wb_sel;
            mem.store      <= dec.store;
            redirect_pc    <= dec.pc + dec.imm;
        end
    end

endmodule

//--- src/mem_wb_unit.sv
`timescale 1ns/1ps

module mem_wb_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    ex_mem_link.slave            ex,
    output logic                 dmem_cyc,
    output logic                 dmem_stb,
    output logic                 dmem_we,
    output rv_isa_pkg::addr_t    dmem_adr,
    output rv_isa_pkg::xlen_t    dmem_wdata,
    input  rv_isa_pkg::xlen_t    dmem_rdata,
    input  logic                 dmem_ack,
    output logic                 wb_we,
    output rv_isa_pkg::reg_idx_t wb_addr,
    output rv_isa_pkg::xlen_t    wb_data
);

    rv_pipe_pkg::bus_state_e state;
    logic mem_op;

    assign mem_op = ex.valid && (ex.store || ex.wb_sel == rv_pipe_pkg::wb_mem);
    // held from arrival of ld/sd through the ack cycle's edge
    assign ex.busy = mem_op && !(state == rv_pipe_pkg::bus_wait && dmem_ack);

    // ------------------------------------------------------------------
    // data bus FSM and writeback enable
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= rv_pipe_pkg::bus_idle;
            dmem_cyc <= 1'b0;
            dmem_stb <= 1'b0;
            dmem_we  <= 1'b0;
            wb_we    <= 1'b0;
        end else begin
            wb_we <= 1'b0;
            case (state)
                rv_pipe_pkg::bus_idle: begin
                    if (mem_op) begin
                        dmem_cyc <= 1'b1;
                        dmem_stb <= 1'b1;
                        dmem_we  <= ex.store;
                        state    <= rv_pipe_pkg::bus_wait;
                    end else if (ex.valid && ex.wb_sel != rv_pipe_pkg::wb_none) begin
                        wb_we <= 1'b1;
                    end
                end
                rv_pipe_pkg::bus_wait: begin
                    if (dmem_ack) begin
                        dmem_cyc <= 1'b0;
                        dmem_stb <= 1'b0;
                        dmem_we  <= 1'b0;
                        state    <= rv_pipe_pkg::bus_idle;
                        // loads write rd, stores retire here
                        wb_we    <= (ex.wb_sel == rv_pipe_pkg::wb_mem);
                    end
                end
                default: state <= rv_pipe_pkg::bus_idle;
            endcase
        end
    end

    // address and data latched only while idle, so they hold during the cycle
    always_ff @(posedge clk) begin
        if (state == rv_pipe_pkg::bus_idle) begin
            dmem_adr   <= ex.result;
            dmem_wdata <= ex.store_data;
        end
        wb_addr <= ex.rd;
        wb_data <= (ex.wb_sel == rv_pipe_pkg::wb_mem) ? dmem_rdata : ex.result;
    end

    a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_stb && !dmem_ack |=> $stable(dmem_adr));

endmodule

//--- src/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
    input  logic               clk,
    input  logic               rst_n,
    // instruction wishbone
    output logic               imem_cyc,
    output logic               imem_stb,
    output rv_isa_pkg::addr_t  imem_adr,
    input  rv_isa_pkg::instr_t imem_rdata,
    input  logic               imem_ack,
    // data wishbone
    output logic               dmem_cyc,
    output logic               dmem_stb,
    output logic               dmem_we,
    output rv_isa_pkg::addr_t  dmem_adr,
    output rv_isa_pkg::xlen_t  dmem_wdata,
    input  rv_isa_pkg::xlen_t  dmem_rdata,
    input  logic               dmem_ack
);

    // fetch to decode
    logic f_valid, f_hold;
    rv_isa_pkg::addr_t  f_pc;
    rv_isa_pkg::instr_t f_instr;
    // branch redirect, also the flush
    logic redirect;
    rv_isa_pkg::addr_t redirect_pc;
    // register file read and writeback
    rv_isa_pkg::reg_idx_t rf_raddr1, rf_raddr2, wb_addr;
    rv_isa_pkg::xlen_t    rf_rdata1, rf_rdata2, wb_data;
    logic wb_we;

    dec_ex_link dec_ex ();
    ex_mem_link ex_mem ();

    fetch_unit u_fetch (
        .clk, .rst_n, .imem_cyc, .imem_stb, .imem_adr, .imem_rdata, .imem_ack,
        .hold(f_hold), .redirect, .redirect_pc,
        .valid(f_valid), .pc(f_pc), .instr(f_instr)
    );

    decode_unit u_decode (
        .clk, .rst_n, .valid(f_valid), .pc(f_pc), .instr(f_instr), .hold(f_hold),
        .redirect, .wb_we, .wb_addr, .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
        .ex(dec_ex.master)
    );

    reg_file u_regs (
        .clk, .raddr1(rf_raddr1), .raddr2(rf_raddr2), .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .we(wb_we), .waddr(wb_addr), .wdata(wb_data)
    );

    execute_unit u_execute (
        .clk, .rst_n, .dec(dec_ex.slave), .mem(ex_mem.master), .redirect, .redirect_pc
    );

    mem_wb_unit u_mem_wb (
        .clk, .rst_n, .ex(ex_mem.slave), .dmem_cyc, .dmem_stb, .dmem_we, .dmem_adr,
        .dmem_wdata, .dmem_rdata, .dmem_ack, .wb_we, .wb_addr, .wb_data
    );

endmodule

//--- testbench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    // ------------------------------------------------------------------
    // DUT ports
    // ------------------------------------------------------------------
    logic clk;
    logic rst_n;
    logic imem_cyc, imem_stb, imem_ack;
    rv_isa_pkg::addr_t  imem_adr;
    rv_isa_pkg::instr_t imem_rdata;
    logic dmem_cyc, dmem_stb, dmem_we, dmem_ack;
    rv_isa_pkg::addr_t dmem_adr;
    rv_isa_pkg::xlen_t dmem_wdata, dmem_rdata;

    // memory images and expected stores from the golden file
    rv_isa_pkg::instr_t imem [rv_isa_pkg::addr_t];
    rv_isa_pkg::xlen_t  dmem [rv_isa_pkg::addr_t];
    rv_isa_pkg::addr_t  exp_addr [$];
    rv_isa_pkg::xlen_t  exp_data [$];
    int n_instr = 0;
    int store_idx = 0;
    int cycles = 0;
    int cycle_limit = 0;
    bit first_fetch_seen = 1'b0;

    // wait-state generators, one per port
    int unsigned i_seed = 26;
    int unsigned d_seed = 26;
    int i_left, d_left;
    bit i_started, d_started;

    rv_core_top DUT (
        .clk, .rst_n,
        .imem_cyc, .imem_stb, .imem_adr, .imem_rdata, .imem_ack,
        .dmem_cyc, .dmem_stb, .dmem_we, .dmem_adr, .dmem_wdata, .dmem_rdata, .dmem_ack
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // unmapped data reads, every address bit mixed in
    function automatic rv_isa_pkg::xlen_t fill_word(input rv_isa_pkg::addr_t adr);
        return adr * 64'h9e37_79b9_7f4a_7c15;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input rv_isa_pkg::addr_t expected,
                              input rv_isa_pkg::addr_t actual);
        if (actual !== expected)
            fail_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_data(input string name, input rv_isa_pkg::xlen_t expected,
                              input rv_isa_pkg::xlen_t actual);
        if (actual !== expected)
            fail_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            fail_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
    endtask

    // ------------------------------------------------------------------
    // wishbone slave models, 0 to 3 wait states per transfer
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            imem_ack <= 1'b0;
            i_started = 1'b0;
        end else if (imem_ack) begin
            // master drops stb on this edge
            imem_ack <= 1'b0;
        end else if (imem_cyc && imem_stb) begin
            if (!i_started) begin
                i_seed    = lcg_next(i_seed);
                i_left    = (i_seed >> 16) % 4;
                i_started = 1'b1;
            end
            if (i_left == 0) begin
                imem_ack   <= 1'b1;
                // past the program end the core only sees addi x0 nops
                imem_rdata <= imem.exists(imem_adr) ? imem[imem_adr] : 32'h0000_0013;
                i_started  = 1'b0;
            end else begin
                i_left = i_left - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            dmem_ack <= 1'b0;
            d_started = 1'b0;
        end else if (dmem_ack) begin
            dmem_ack <= 1'b0;
        end else if (dmem_cyc && dmem_stb) begin
            if (!d_started) begin
                d_seed    = lcg_next(d_seed);
                d_left    = (d_seed >> 16) % 4;
                d_started = 1'b1;
            end
            if (d_left == 0) begin
                dmem_ack  <= 1'b1;
                d_started = 1'b0;
                if (dmem_we)
                    dmem[dmem_adr] = dmem_wdata;
                else
                    dmem_rdata <= dmem.exists(dmem_adr) ? dmem[dmem_adr] : fill_word(dmem_adr);
            end else begin
                d_left = d_left - 1;
            end
        end
    end

    // ------------------------------------------------------------------
    // monitors
    // ------------------------------------------------------------------
    // program starts at address zero
    always @(posedge clk) begin
        if (rst_n && imem_stb && !first_fetch_seen) begin
            check_addr("imem_adr", 64'h0, imem_adr);
            first_fetch_seen = 1'b1;
        end
    end

    // each write ack against the next golden store, in order
    always @(posedge clk) begin
        if (rst_n && dmem_ack && dmem_we) begin
            if (store_idx >= exp_addr.size()) begin
                fail_run($sformatf("unexpected store to address %h after the expected list",
                                   dmem_adr));
            end else begin
                check_addr("dmem_adr", exp_addr[store_idx], dmem_adr);
                check_data("dmem_wdata", exp_data[store_idx], dmem_wdata);
                store_idx = store_idx + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycles = cycles + 1;
            if (cycles >= cycle_limit)
                fail_run("the run timed out before all expected stores were seen");
        end
    end

    // ------------------------------------------------------------------
    // golden load, reset and end of run
    // ------------------------------------------------------------------
    initial begin
        int fd;
        int code;
        int kind;
        string line;
        rv_isa_pkg::addr_t adr;
        rv_isa_pkg::xlen_t val;
        rst_n      = 1'b0;
        imem_ack   = 1'b0;
        imem_rdata = '0;
        dmem_ack   = 1'b0;
        dmem_rdata = '0;
        fd = $fopen("testbench/core_golden.txt", "r");
        if (fd == 0)
            fail_run("cannot open testbench/core_golden.txt");
        while ($fgets(line, fd) != 0) begin
            // comment lines start with a hash
            if (line.len() > 0 && line.getc(0) != "#") begin
                code = $sscanf(line, "%c %h %h", kind, adr, val);
                if (code == 3) begin
                    case (kind)
                        "I": begin
                            imem[adr] = val[31:0];
                            n_instr   = n_instr + 1;
                        end
                        "D": dmem[adr] = val;
                        "S": begin
                            exp_addr.push_back(adr);
                            exp_data.push_back(val);
                        end
                        default: fail_run("golden file holds a line of unknown kind");
                    endcase
                end
            end
        end
        $fclose(fd);
        if (n_instr == 0 || exp_addr.size() == 0)
            fail_run("golden file holds no program or no expected stores");
        cycle_limit = 40 * (n_instr + exp_addr.size());

        // both buses stay quiet while reset is held
        for (int k = 0; k < 10; k++) begin
            @(posedge clk);
            if (k > 0) begin
                check_flag("imem_cyc", 1'b0, imem_cyc);
                check_flag("imem_stb", 1'b0, imem_stb);
                check_flag("dmem_cyc", 1'b0, dmem_cyc);
                check_flag("dmem_stb", 1'b0, dmem_stb);
                check_flag("dmem_we", 1'b0, dmem_we);
            end
        end
        rst_n <= 1'b1;

        while (store_idx < exp_addr.size())
            @(negedge clk);
        // quiet window, the parked loop must not store again
        repeat (40) @(negedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

//--- src.f
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/pipe_links.sv
src/fetch_unit.sv
src/decode_unit.sv
src/reg_file.sv
src/execute_unit.sv
src/mem_wb_unit.sv
src/rv_core_top.sv
testbench/tb_rv_core.sv

//--- testbench/core_golden.txt
# kind addr value, hex; I = program word, D = initial data word
# S = expected store address and data, listed in bus order
I 0000 40000093  # addi x1, x0, 1024     data base 0x400
I 0004 6a500113  # addi x2, x0, 0x6a5
I 0008 d0f00193  # addi x3, x0, -0x2f1
I 000c 00310233  # add  x4, x2, x3
I 0010 0040b023  # sd   x4, 0(x1)
I 0014 403102b3  # sub  x5, x2, x3
I 0018 0050b423  # sd   x5, 8(x1)
I 001c 00317333  # and  x6, x2, x3
I 0020 0060b823  # sd   x6, 16(x1)
I 0024 003163b3  # or   x7, x2, x3
I 0028 0070bc23  # sd   x7, 24(x1)
I 002c 00314433  # xor  x8, x2, x3
I 0030 0280b023  # sd   x8, 32(x1)
I 0034 00510013  # addi x0, x2, 5        x0 stays zero
I 0038 0200b423  # sd   x0, 40(x1)
I 003c 1000b483  # ld   x9, 256(x1)
I 0040 00748513  # addi x10, x9, 7       load-use interlock
I 0044 02a0b823  # sd   x10, 48(x1)
I 0048 00310463  # beq  x2, x3, +8       not taken
I 004c 0220bc23  # sd   x2, 56(x1)
I 0050 00311663  # bne  x2, x3, +12      taken
I 0054 0430b023  # sd   x3, 64(x1)       flushed
I 0058 0430b423  # sd   x3, 72(x1)       flushed
I 005c 00420663  # beq  x4, x4, +12      taken
I 0060 0420b823  # sd   x2, 80(x1)       flushed
I 0064 0420bc23  # sd   x2, 88(x1)       flushed
I 0068 00211463  # bne  x2, x2, +8       not taken
I 006c 00c005ef  # jal  x11, +12
I 0070 0620b023  # sd   x2, 96(x1)       flushed
I 0074 0620b423  # sd   x2, 104(x1)      flushed
I 0078 06b0b823  # sd   x11, 112(x1)     link value
I 007c 0000006f  # jal  x0, 0            park
D 0500 0123456789abcdef
S 0400 00000000000003b4
S 0408 0000000000000996
S 0410 0000000000000405
S 0418 ffffffffffffffaf
S 0420 fffffffffffffbaa
S 0428 0000000000000000
S 0430 0123456789abcdf6
S 0438 00000000000006a5
S 0470 0000000000000070
